// File: rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_BRANCH  = 7'b1100011,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_ENVIRON = 7'b1110011
  } opcode_e;

  // decoded operation carried from decode to execute
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI,
    ALU_ANDI, ALU_SLLI, ALU_SRLI, ALU_SRAI, ALU_LUI,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU,
    ALU_BGEU, ALU_ECALL, ALU_NOP
  } alu_op_e;

  // funct3 for the alu groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  // selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

  // what occupies writeback in a given cycle, one-hot
  typedef enum logic [31:0] {
    CYCLE_INVALID      = 32'd0,
    CYCLE_RESET        = 32'd1,
    CYCLE_NO_STALL     = 32'd2,
    CYCLE_TAKEN_BRANCH = 32'd4
  } cycle_status_e;

  // contents of the decode register
  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t insn;
    cycle_status_e     status;
  } decode_rec_t;

  // contents of the execute register, operands already read
  typedef struct packed {
    rv_isa_pkg::word_t   pc;
    rv_isa_pkg::word_t   insn;
    rv_isa_pkg::alu_op_e op;
    rv_isa_pkg::word_t   rs1_data;
    rv_isa_pkg::word_t   rs2_data;
    cycle_status_e       status;
  } execute_rec_t;

  // memory and writeback registers share this layout
  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    insn;
    rv_isa_pkg::word_t    rd_data;
    logic                 we;
    rv_isa_pkg::reg_idx_t rd;
    logic                 halt;
    cycle_status_e        status;
  } retire_rec_t;

endpackage

// File: exec_if.sv
`timescale 1ns/100ps

interface exec_if (
  input logic clk
);

  rv_isa_pkg::alu_op_e op;
  rv_isa_pkg::word_t   a;
  rv_isa_pkg::word_t   b;
  rv_isa_pkg::word_t   imm;
  rv_isa_pkg::word_t   pc;
  rv_isa_pkg::word_t   alu_result;
  logic                alu_we;
  logic                take;
  rv_isa_pkg::word_t   target;

  modport src (output op, a, b, imm, pc);
  modport alu (input op, a, b, imm, output alu_result, alu_we);
  // clock only for the branch unit's checker
  modport br (input clk, op, a, b, imm, pc, output take, target);

endinterface

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // retire logic drops x0 writes before they get here
  no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> rd != '0);

endmodule

// File: alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
  exec_if.alu bus
);

  always_comb begin
    bus.alu_result = '0;
    bus.alu_we = 1'b1;
    case (bus.op)
      rv_isa_pkg::ALU_ADD: bus.alu_result = bus.a + bus.b;
      rv_isa_pkg::ALU_SUB: bus.alu_result = bus.a - bus.b;
      rv_isa_pkg::ALU_SLL: bus.alu_result = bus.a << bus.b[4:0];
      rv_isa_pkg::ALU_SLT: bus.alu_result = {31'b0, $signed(bus.a) < $signed(bus.b)};
      rv_isa_pkg::ALU_SLTU: bus.alu_result = {31'b0, bus.a < bus.b};
      rv_isa_pkg::ALU_XOR: bus.alu_result = bus.a ^ bus.b;
      rv_isa_pkg::ALU_SRL: bus.alu_result = bus.a >> bus.b[4:0];
      rv_isa_pkg::ALU_SRA: bus.alu_result = $signed(bus.a) >>> bus.b[4:0];
      rv_isa_pkg::ALU_OR: bus.alu_result = bus.a | bus.b;
      rv_isa_pkg::ALU_AND: bus.alu_result = bus.a & bus.b;
      // immediate forms
      rv_isa_pkg::ALU_ADDI: bus.alu_result = bus.a + bus.imm;
      rv_isa_pkg::ALU_SLTI: bus.alu_result = {31'b0, $signed(bus.a) < $signed(bus.imm)};
      rv_isa_pkg::ALU_SLTIU: bus.alu_result = {31'b0, bus.a < bus.imm};
      rv_isa_pkg::ALU_XORI: bus.alu_result = bus.a ^ bus.imm;
      rv_isa_pkg::ALU_ORI: bus.alu_result = bus.a | bus.imm;
      rv_isa_pkg::ALU_ANDI: bus.alu_result = bus.a & bus.imm;
      rv_isa_pkg::ALU_SLLI: bus.alu_result = bus.a << bus.imm[4:0];
      rv_isa_pkg::ALU_SRLI: bus.alu_result = bus.a >> bus.imm[4:0];
      rv_isa_pkg::ALU_SRAI: bus.alu_result = $signed(bus.a) >>> bus.imm[4:0];
      // imm already holds the upper immediate here
      rv_isa_pkg::ALU_LUI: bus.alu_result = bus.imm;
      // branches, ecall and nop leave rd alone
      default: bus.alu_we = 1'b0;
    endcase
  end

endmodule

// File: branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
  exec_if.br bus
);

  logic is_branch;
  logic cond;

  always_comb begin
    is_branch = 1'b1;
    cond = 1'b0;
    case (bus.op)
      rv_isa_pkg::ALU_BEQ: cond = bus.a == bus.b;
      rv_isa_pkg::ALU_BNE: cond = bus.a != bus.b;
      rv_isa_pkg::ALU_BLT: cond = $signed(bus.a) < $signed(bus.b);
      rv_isa_pkg::ALU_BGE: cond = $signed(bus.a) >= $signed(bus.b);
      rv_isa_pkg::ALU_BLTU: cond = bus.a < bus.b;
      rv_isa_pkg::ALU_BGEU: cond = bus.a >= bus.b;
      default: is_branch = 1'b0;
    endcase
  end

  assign bus.take = is_branch && cond;
  // pc relative, imm is the B immediate for branches
  assign bus.target = bus.pc + bus.imm;

  target_aligned: assert property (@(posedge bus.clk) bus.take |-> bus.target[1:0] == 2'b00);

endmodule

// File: fetch_decode.sv
`timescale 1ns/100ps

module fetch_decode #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     take,
  input  rv_isa_pkg::word_t        target,
  input  logic                     wb_we,
  input  rv_isa_pkg::reg_idx_t     wb_rd,
  input  rv_isa_pkg::word_t        wb_data,
  output rv_isa_pkg::word_t        pc_to_imem,
  input  rv_isa_pkg::word_t        insn_from_imem,
  output rv_pipe_pkg::execute_rec_t dec_out
);

  rv_isa_pkg::word_t        pc;
  rv_pipe_pkg::decode_rec_t dec_q;
  rv_isa_pkg::opcode_e      opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  rv_isa_pkg::reg_idx_t     rs1;
  rv_isa_pkg::reg_idx_t     rs2;
  rv_isa_pkg::word_t        rf_rs1_data;
  rv_isa_pkg::word_t        rf_rs2_data;
  rv_isa_pkg::alu_op_e      op;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (take) begin
      pc <= target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign pc_to_imem = pc;

  // redirect squashes whatever was just fetched
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_RESET};
    end else if (take) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_TAKEN_BRANCH};
    end else begin
      dec_q <= '{pc: pc, insn: insn_from_imem, status: rv_pipe_pkg::CYCLE_NO_STALL};
    end
  end

  assign opcode = rv_isa_pkg::opcode_e'(dec_q.insn[6:0]);
  assign funct3 = dec_q.insn[14:12];
  assign funct7 = dec_q.insn[31:25];
  assign rs1 = dec_q.insn[19:15];
  assign rs2 = dec_q.insn[24:20];

  always_comb begin
    op = rv_isa_pkg::ALU_NOP;
    case (opcode)
      rv_isa_pkg::OP_LUI: op = rv_isa_pkg::ALU_LUI;
      rv_isa_pkg::OP_BRANCH: begin
        case (funct3)
          rv_isa_pkg::F3_BEQ: op = rv_isa_pkg::ALU_BEQ;
          rv_isa_pkg::F3_BNE: op = rv_isa_pkg::ALU_BNE;
          rv_isa_pkg::F3_BLT: op = rv_isa_pkg::ALU_BLT;
          rv_isa_pkg::F3_BGE: op = rv_isa_pkg::ALU_BGE;
          rv_isa_pkg::F3_BLTU: op = rv_isa_pkg::ALU_BLTU;
          rv_isa_pkg::F3_BGEU: op = rv_isa_pkg::ALU_BGEU;
          default: op = rv_isa_pkg::ALU_NOP;
        endcase
      end
      rv_isa_pkg::OP_REG_IMM: begin
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: op = rv_isa_pkg::ALU_ADDI;
          rv_isa_pkg::F3_SLT: op = rv_isa_pkg::ALU_SLTI;
          rv_isa_pkg::F3_SLTU: op = rv_isa_pkg::ALU_SLTIU;
          rv_isa_pkg::F3_XOR: op = rv_isa_pkg::ALU_XORI;
          rv_isa_pkg::F3_OR: op = rv_isa_pkg::ALU_ORI;
          rv_isa_pkg::F3_AND: op = rv_isa_pkg::ALU_ANDI;
          rv_isa_pkg::F3_SLL: begin
            if (funct7 == rv_isa_pkg::FUNCT7_BASE) op = rv_isa_pkg::ALU_SLLI;
          end
          default: begin
            // shift right, funct7 picks logical or arithmetic
            if (funct7 == rv_isa_pkg::FUNCT7_BASE) op = rv_isa_pkg::ALU_SRLI;
            else if (funct7 == rv_isa_pkg::FUNCT7_ALT) op = rv_isa_pkg::ALU_SRAI;
          end
        endcase
      end
      rv_isa_pkg::OP_REG_REG: begin
        if (funct7 == rv_isa_pkg::FUNCT7_BASE) begin
          case (funct3)
            rv_isa_pkg::F3_ADD_SUB: op = rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL: op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT: op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR: op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR: op = rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR: op = rv_isa_pkg::ALU_OR;
            default: op = rv_isa_pkg::ALU_AND;
          endcase
        end else if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
          if (funct3 == rv_isa_pkg::F3_ADD_SUB) op = rv_isa_pkg::ALU_SUB;
          else if (funct3 == rv_isa_pkg::F3_SR) op = rv_isa_pkg::ALU_SRA;
        end
      end
      rv_isa_pkg::OP_ENVIRON: begin
        if (dec_q.insn[31:7] == '0) op = rv_isa_pkg::ALU_ECALL;
      end
      default: op = rv_isa_pkg::ALU_NOP;
    endcase
  end

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_we),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  // writeback to decode bypass, same cycle as the register write
  always_comb begin
    dec_out.pc = dec_q.pc;
    dec_out.insn = dec_q.insn;
    dec_out.op = op;
    dec_out.status = dec_q.status;
    dec_out.rs1_data = (wb_we && wb_rd != '0 && wb_rd == rs1) ? wb_data : rf_rs1_data;
    dec_out.rs2_data = (wb_we && wb_rd != '0 && wb_rd == rs2) ? wb_data : rf_rs2_data;
  end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: exec_retire.sv
`timescale 1ns/100ps

module exec_retire (
  input  logic                      clk,
  input  logic                      rst,
  input  rv_pipe_pkg::execute_rec_t dec_in,
  output logic                      take,
  output rv_isa_pkg::word_t         target,
  output logic                      wb_we,
  output rv_isa_pkg::reg_idx_t      wb_rd,
  output rv_isa_pkg::word_t         wb_data,
  output logic                      halt,
  output rv_pipe_pkg::retire_rec_t  trace
);

  rv_pipe_pkg::execute_rec_t ex_q;
  rv_pipe_pkg::retire_rec_t  mem_d;
  rv_pipe_pkg::retire_rec_t  mem_q;
  rv_pipe_pkg::retire_rec_t  wb_q;
  rv_isa_pkg::reg_idx_t      rs1_x;
  rv_isa_pkg::reg_idx_t      rs2_x;
  rv_isa_pkg::reg_idx_t      rd_x;
  rv_isa_pkg::word_t         imm_i;
  rv_isa_pkg::word_t         imm_b;
  rv_isa_pkg::word_t         imm_u;

  exec_if ex_bus (.clk(clk));

  // pick the youngest producer of src, memory stage first
  function automatic rv_isa_pkg::word_t fwd(
    input rv_isa_pkg::reg_idx_t     src,
    input rv_isa_pkg::word_t        reg_val,
    input rv_pipe_pkg::retire_rec_t m,
    input rv_pipe_pkg::retire_rec_t w
  );
    if (m.we && m.rd != '0 && m.rd == src) return m.rd_data;
    if (w.we && w.rd != '0 && w.rd == src) return w.rd_data;
    return reg_val;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_q <= '{pc: '0, insn: '0, op: rv_isa_pkg::ALU_NOP, rs1_data: '0, rs2_data: '0,
                status: rv_pipe_pkg::CYCLE_RESET};
    end else if (take) begin
      ex_q <= '{pc: '0, insn: '0, op: rv_isa_pkg::ALU_NOP, rs1_data: '0, rs2_data: '0,
                status: rv_pipe_pkg::CYCLE_TAKEN_BRANCH};
    end else begin
      ex_q <= dec_in;
    end
  end

  assign rs1_x = ex_q.insn[19:15];
  assign rs2_x = ex_q.insn[24:20];
  assign rd_x = ex_q.insn[11:7];

  assign imm_i = {{20{ex_q.insn[31]}}, ex_q.insn[31:20]};
  assign imm_b = {{20{ex_q.insn[31]}}, ex_q.insn[7], ex_q.insn[30:25], ex_q.insn[11:8], 1'b0};
  assign imm_u = {ex_q.insn[31:12], 12'b0};

  always_comb begin
    ex_bus.op = ex_q.op;
    ex_bus.pc = ex_q.pc;
    ex_bus.a = fwd(rs1_x, ex_q.rs1_data, mem_q, wb_q);
    ex_bus.b = fwd(rs2_x, ex_q.rs2_data, mem_q, wb_q);
    case (ex_q.op)
      rv_isa_pkg::ALU_BEQ, rv_isa_pkg::ALU_BNE, rv_isa_pkg::ALU_BLT,
      rv_isa_pkg::ALU_BGE, rv_isa_pkg::ALU_BLTU, rv_isa_pkg::ALU_BGEU: ex_bus.imm = imm_b;
      rv_isa_pkg::ALU_LUI: ex_bus.imm = imm_u;
      default: ex_bus.imm = imm_i;
    endcase
  end

  alu_unit u_alu (.bus(ex_bus.alu));

  branch_unit u_branch (.bus(ex_bus.br));

  assign take = ex_bus.take;
  assign target = ex_bus.target;

  // x0 writes are dropped here so later stages never see them
  always_comb begin
    mem_d.pc = ex_q.pc;
    mem_d.insn = ex_q.insn;
    mem_d.rd_data = ex_bus.alu_result;
    mem_d.we = ex_bus.alu_we && rd_x != '0;
    mem_d.rd = rd_x;
    mem_d.halt = ex_q.op == rv_isa_pkg::ALU_ECALL;
    mem_d.status = ex_q.status;
  end

  // no data memory, so memory and writeback are plain register stages
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q <= '{pc: '0, insn: '0, rd_data: '0, we: 1'b0, rd: '0, halt: 1'b0,
                 status: rv_pipe_pkg::CYCLE_RESET};
      wb_q <= '{pc: '0, insn: '0, rd_data: '0, we: 1'b0, rd: '0, halt: 1'b0,
                status: rv_pipe_pkg::CYCLE_RESET};
    end else begin
      mem_q <= mem_d;
      wb_q <= mem_q;
    end
  end

  assign wb_we = wb_q.we;
  assign wb_rd = wb_q.rd;
  assign wb_data = wb_q.rd_data;
  assign halt = wb_q.halt;
  assign trace = wb_q;

  wb_status_valid: assert property (
    @(posedge clk) disable iff (rst) wb_q.status != rv_pipe_pkg::CYCLE_INVALID
  );

endmodule

// File: rv_pipeline.sv
`timescale 1ns/100ps

module rv_pipeline #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h0
) (
  input  logic                       clk,
  input  logic                       rst,
  output rv_isa_pkg::word_t          pc_to_imem,
  input  rv_isa_pkg::word_t          insn_from_imem,
  output logic                       halt,
  output rv_isa_pkg::word_t          trace_pc,
  output rv_isa_pkg::word_t          trace_insn,
  output rv_pipe_pkg::cycle_status_e trace_status,
  output logic                       trace_we,
  output rv_isa_pkg::reg_idx_t       trace_rd,
  output rv_isa_pkg::word_t          trace_data
);

  rv_pipe_pkg::execute_rec_t dec;
  logic                      take;
  rv_isa_pkg::word_t         target;
  logic                      wb_we;
  rv_isa_pkg::reg_idx_t      wb_rd;
  rv_isa_pkg::word_t         wb_data;
  rv_pipe_pkg::retire_rec_t  trace_rec;

  fetch_decode #(
    .RESET_PC (RESET_PC)
  ) u_fetch_decode (
    .clk            (clk),
    .rst            (rst),
    .take           (take),
    .target         (target),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .dec_out        (dec)
  );

  exec_retire u_exec_retire (
    .clk     (clk),
    .rst     (rst),
    .dec_in  (dec),
    .take    (take),
    .target  (target),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .halt    (halt),
    .trace   (trace_rec)
  );

  // writeback record out to the trace pins
  assign trace_pc = trace_rec.pc;
  assign trace_insn = trace_rec.insn;
  assign trace_status = trace_rec.status;
  assign trace_we = trace_rec.we;
  assign trace_rd = trace_rec.rd;
  assign trace_data = trace_rec.rd_data;

endmodule

// File: tb_rv_pipeline.sv
`timescale 1ns/100ps

module tb_rv_pipeline;

  localparam rv_isa_pkg::word_t RESET_PC = 32'h40;
  localparam int N_TESTS = 5;
  localparam int N_ENTRIES = 40;
  localparam int WATCHDOG_NS = N_TESTS * 64 * 20;

  // encodings as the ISA manual gives them
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_IMM = 7'b0010011;
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;
  localparam rv_isa_pkg::word_t ECALL = 32'h00000073;

  logic                       clk;
  logic                       rst;
  rv_isa_pkg::word_t          pc_to_imem;
  rv_isa_pkg::word_t          insn_from_imem;
  logic                       halt;
  rv_isa_pkg::word_t          trace_pc;
  rv_isa_pkg::word_t          trace_insn;
  rv_pipe_pkg::cycle_status_e trace_status;
  logic                       trace_we;
  rv_isa_pkg::reg_idx_t       trace_rd;
  rv_isa_pkg::word_t          trace_data;

  rv_isa_pkg::word_t        imem [64];
  rv_isa_pkg::word_t        prog [$];
  rv_pipe_pkg::retire_rec_t exp_q [$];
  logic [15:0]              lfsr;

  rv_pipeline #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .halt           (halt),
    .trace_pc       (trace_pc),
    .trace_insn     (trace_insn),
    .trace_status   (trace_status),
    .trace_we       (trace_we),
    .trace_rd       (trace_rd),
    .trace_data     (trace_data)
  );

  assign insn_from_imem = imem[pc_to_imem[7:2]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("timeout: the tests did not finish within the watchdog limit");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                            input rv_isa_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input rv_pipe_pkg::cycle_status_e got,
                              input rv_pipe_pkg::cycle_status_e exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rd(input string name, input rv_isa_pkg::reg_idx_t got,
                          input rv_isa_pkg::reg_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic rv_isa_pkg::word_t enc_i(input logic [2:0] f3, input int rd,
                                              input int rs1, input rv_isa_pkg::word_t imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], OPC_IMM};
  endfunction

  function automatic rv_isa_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                              input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_REG};
  endfunction

  function automatic rv_isa_pkg::word_t enc_b(input logic [2:0] f3, input int rs1,
                                              input int rs2, input int off);
    rv_isa_pkg::word_t o;
    o = off;
    return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], OPC_BRANCH};
  endfunction

  function automatic rv_isa_pkg::word_t enc_u(input int rd, input rv_isa_pkg::word_t imm20);
    return {imm20[19:0], rd[4:0], OPC_LUI};
  endfunction

  // unused slots hold addi x0, x0, slot
  task automatic load_program();
    logic [5:0] slot;
    for (int i = 0; i < 64; i++) begin
      imem[i[5:0]] = enc_i(3'd0, 0, 0, i);
    end
    slot = RESET_PC[7:2];
    for (int i = 0; i < prog.size(); i++) begin
      imem[slot] = prog[i];
      slot = slot + 6'd1;
    end
  endtask

  // in-order ISA model, emits the writeback sequence the trace should show
  task automatic build_expected();
    rv_isa_pkg::word_t        mregs [32];
    rv_isa_pkg::word_t        pc;
    rv_isa_pkg::word_t        insn;
    rv_isa_pkg::word_t        a;
    rv_isa_pkg::word_t        b;
    rv_isa_pkg::word_t        imm_i;
    rv_isa_pkg::word_t        imm_b;
    rv_isa_pkg::word_t        res;
    logic                     writes;
    logic                     taken;
    rv_pipe_pkg::retire_rec_t rec;
    rv_pipe_pkg::retire_rec_t bubble;
    exp_q.delete();
    for (int r = 0; r < 32; r++) begin
      mregs[r[4:0]] = '0;
    end
    bubble = '0;
    bubble.status = rv_pipe_pkg::CYCLE_RESET;
    repeat (4) exp_q.push_back(bubble);
    bubble.status = rv_pipe_pkg::CYCLE_TAKEN_BRANCH;
    pc = RESET_PC;
    while (exp_q.size() < N_ENTRIES) begin
      insn = imem[pc[7:2]];
      a = mregs[insn[19:15]];
      b = mregs[insn[24:20]];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      res = '0;
      writes = 1'b1;
      taken = 1'b0;
      case (insn[6:0])
        OPC_LUI: res = {insn[31:12], 12'h000};
        OPC_IMM: begin
          case (insn[14:12])
            3'd0: res = a + imm_i;
            3'd1: res = a << imm_i[4:0];
            3'd2: res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
            3'd3: res = (a < imm_i) ? 32'd1 : 32'd0;
            3'd4: res = a ^ imm_i;
            3'd5: begin
              // bit 30 picks arithmetic over logical
              if (insn[30]) begin
                res = $signed(a) >>> imm_i[4:0];
              end else begin
                res = a >> imm_i[4:0];
              end
            end
            3'd6: res = a | imm_i;
            default: res = a & imm_i;
          endcase
        end
        OPC_REG: begin
          case (insn[14:12])
            3'd0: res = insn[30] ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
              if (insn[30]) begin
                res = $signed(a) >>> b[4:0];
              end else begin
                res = a >> b[4:0];
              end
            end
            3'd6: res = a | b;
            default: res = a & b;
          endcase
        end
        OPC_BRANCH: begin
          writes = 1'b0;
          case (insn[14:12])
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            3'd7: taken = a >= b;
            default: taken = 1'b0;
          endcase
        end
        default: writes = 1'b0;
      endcase
      rec.pc = pc;
      rec.insn = insn;
      rec.rd_data = res;
      rec.we = writes && (insn[11:7] != 5'd0);
      rec.rd = insn[11:7];
      rec.halt = (insn == ECALL);
      rec.status = rv_pipe_pkg::CYCLE_NO_STALL;
      exp_q.push_back(rec);
      if (rec.we) begin
        mregs[insn[11:7]] = res;
      end
      // the two younger instructions become bubbles
      if (taken) begin
        repeat (2) exp_q.push_back(bubble);
        pc = pc + imm_b;
      end else begin
        pc = pc + 32'd4;
      end
    end
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  // outputs settle between edges, so sample on the falling edge
  task automatic compare_trace();
    for (int k = 0; k < exp_q.size(); k++) begin
      @(negedge clk);
      check_status("trace_status", trace_status, exp_q[k].status);
      check_word("trace_pc", trace_pc, exp_q[k].pc);
      check_word("trace_insn", trace_insn, exp_q[k].insn);
      check_bit("trace_we", trace_we, exp_q[k].we);
      check_rd("trace_rd", trace_rd, exp_q[k].rd);
      check_word("trace_data", trace_data, exp_q[k].rd_data);
      check_bit("halt", halt, exp_q[k].halt);
    end
  endtask

  task automatic run_program();
    load_program();
    build_expected();
    pulse_reset();
    compare_trace();
  endtask

  task automatic test_reset_sequence();
    prog.delete();
    prog.push_back(enc_i(3'd0, 1, 0, 5));
    prog.push_back(enc_i(3'd0, 2, 1, 3));
    prog.push_back(enc_r(F7_BASE, 3'd0, 3, 1, 2));
    run_program();
  endtask

  // distance 1 uses MX, distance 2 WX, distance 3 the decode bypass
  task automatic test_alu_chain();
    prog.delete();
    prog.push_back(enc_i(3'd0, 5, 0, rand_bits(12)));
    prog.push_back(enc_i(3'd4, 5, 5, rand_bits(12)));
    prog.push_back(enc_i(3'd2, 6, 5, rand_bits(12)));
    prog.push_back(enc_i(3'd5, 7, 5, 32'h400 | rand_bits(5)));
    prog.push_back(enc_r(F7_BASE, 3'd0, 8, 7, 5));
    prog.push_back(enc_r(F7_ALT, 3'd0, 9, 8, 6));
    prog.push_back(enc_r(F7_BASE, 3'd1, 10, 9, 7));
    prog.push_back(enc_r(F7_BASE, 3'd2, 11, 10, 9));
    prog.push_back(enc_r(F7_BASE, 3'd3, 12, 9, 11));
    prog.push_back(enc_r(F7_BASE, 3'd4, 13, 12, 10));
    prog.push_back(enc_r(F7_BASE, 3'd5, 14, 13, 8));
    prog.push_back(enc_r(F7_ALT, 3'd5, 15, 9, 14));
    prog.push_back(enc_r(F7_BASE, 3'd6, 16, 15, 13));
    prog.push_back(enc_r(F7_BASE, 3'd7, 17, 16, 9));
    prog.push_back(enc_i(3'd3, 18, 17, rand_bits(12)));
    prog.push_back(enc_i(3'd6, 19, 16, rand_bits(12)));
    prog.push_back(enc_i(3'd7, 20, 19, rand_bits(12)));
    prog.push_back(enc_i(3'd1, 21, 19, rand_bits(5)));
    prog.push_back(enc_i(3'd5, 22, 21, rand_bits(5)));
    prog.push_back(enc_i(3'd0, 23, 22, rand_bits(12)));
    run_program();
  endtask

  task automatic test_x0_writes();
    prog.delete();
    prog.push_back(enc_i(3'd0, 0, 0, rand_bits(12)));
    prog.push_back(enc_i(3'd0, 1, 0, 37));
    prog.push_back(enc_r(F7_BASE, 3'd0, 0, 1, 1));
    prog.push_back(enc_u(0, rand_bits(20)));
    prog.push_back(enc_r(F7_BASE, 3'd0, 2, 0, 1));
    prog.push_back(enc_r(F7_ALT, 3'd0, 3, 0, 0));
    prog.push_back(enc_i(3'd0, 4, 0, -1));
    prog.push_back(enc_r(F7_BASE, 3'd6, 5, 0, 2));
    run_program();
  endtask

  // each branch once taken and once not, taken ones skip one slot
  task automatic test_branches();
    prog.delete();
    prog.push_back(enc_i(3'd0, 1, 0, -5));
    prog.push_back(enc_i(3'd0, 2, 0, 7));
    prog.push_back(enc_i(3'd0, 3, 0, 7));
    prog.push_back(enc_b(3'd0, 2, 3, 8));
    prog.push_back(enc_i(3'd0, 10, 0, 1));
    prog.push_back(enc_b(3'd0, 1, 2, 8));
    prog.push_back(enc_b(3'd1, 1, 2, 8));
    prog.push_back(enc_i(3'd0, 10, 0, 2));
    prog.push_back(enc_b(3'd1, 2, 3, 8));
    prog.push_back(enc_b(3'd4, 1, 2, 8));
    prog.push_back(enc_i(3'd0, 10, 0, 3));
    prog.push_back(enc_b(3'd4, 2, 1, 8));
    prog.push_back(enc_b(3'd5, 2, 1, 8));
    prog.push_back(enc_i(3'd0, 10, 0, 4));
    prog.push_back(enc_b(3'd5, 1, 2, 8));
    prog.push_back(enc_b(3'd6, 2, 1, 8));
    prog.push_back(enc_i(3'd0, 10, 0, 5));
    prog.push_back(enc_b(3'd6, 1, 2, 8));
    prog.push_back(enc_b(3'd7, 1, 2, 8));
    prog.push_back(enc_i(3'd0, 10, 0, 6));
    prog.push_back(enc_b(3'd7, 2, 1, 8));
    prog.push_back(enc_i(3'd0, 13, 10, 1));
    prog.push_back(ECALL);
    run_program();
  endtask

  task automatic test_lui_ecall();
    prog.delete();
    prog.push_back(enc_u(1, rand_bits(20)));
    prog.push_back(enc_i(3'd0, 2, 1, rand_bits(12)));
    prog.push_back(enc_u(3, rand_bits(20)));
    prog.push_back(enc_r(F7_BASE, 3'd4, 4, 3, 2));
    prog.push_back(ECALL);
    prog.push_back(enc_i(3'd0, 5, 4, 1));
    prog.push_back(enc_u(6, rand_bits(20)));
    run_program();
  endtask

  initial begin
    rst = 1'b1;
    lfsr = 16'd3;
    test_reset_sequence();
    test_alu_chain();
    test_x0_writes();
    test_branches();
    test_lui_ecall();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: build.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
exec_if.sv
reg_file.sv
alu_unit.sv
branch_unit.sv
fetch_decode.sv
exec_retire.sv
rv_pipeline.sv
tb_rv_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator, passes only if sim.log holds the pass line
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_rv_pipeline -f build.f -o tb_sim \
  > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "^All checks passed$" sim.log 2> /dev/null && echo "PASS" && exit 0 || echo "FAIL" && exit 1
